// File: src.f
+incdir+include
hw/spu_pkg.sv
hw/instr_decoder.sv
hw/mul_lane.sv
hw/result_pipe.sv
hw/single_precision_unit.sv
verification/tb_single_precision_unit.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the multiply-path testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
  --top-module tb_single_precision_unit \
  --Mdir obj_dir -o tb_sim \
  -f src.f
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit $status
fi

./obj_dir/tb_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit $status
fi

echo "Simulation passed"
exit 0

// File: include/spu_ref_model.svh
// Reference model of the multiply path for the testbench
// Include inside a module that already imports spu_pkg
`ifndef SPU_REF_MODEL_SVH
`define SPU_REF_MODEL_SVH

// Decode to a lane op, OP_NONE for anything not kept
function automatic mul_op_e model_op(logic [2:0] fmt, logic [OPCODE_W-1:0] opc);
  if (fmt == 3'd0 && opc == OPC_MPY) return OP_MPY;
  if (fmt == 3'd0 && opc == OPC_MPYU) return OP_MPYU;
  if (fmt == 3'd0 && opc == OPC_MPYH) return OP_MPYH;
  if (fmt == 3'd0 && opc == OPC_MPYS) return OP_MPYS;
  if (fmt == 3'd1 && opc[3:0] == OPC_MPYA) return OP_MPYA;
  if (fmt == 3'd4 && opc[7:0] == OPC_MPYI) return OP_MPYI;
  if (fmt == 3'd4 && opc[7:0] == OPC_MPYUI) return OP_MPYUI;
  return OP_NONE;
endfunction

// Wide arithmetic, then keep the low lane bits
function automatic word_t model_lane(mul_op_e op, word_t a, word_t b, word_t c,
                                     logic [9:0] imm10);
  longint sa;
  longint sb;
  longint ua;
  longint ub;
  longint r;
  sa = longint'($signed(a[15:0]));
  sb = longint'($signed(b[15:0]));
  ua = longint'(a[15:0]);
  ub = longint'(b[15:0]);
  case (op)
    OP_MPY:   r = sa * sb;
    OP_MPYU:  r = ua * ub;
    OP_MPYH:  r = (longint'(a[31:16]) * ub) << 16;
    OP_MPYS:  r = (sa * sb) >>> 16;
    OP_MPYA:  r = sa * sb + longint'($signed(c));
    OP_MPYI:  r = sa * longint'($signed(imm10));
    OP_MPYUI: r = ua * longint'({{6{imm10[9]}}, imm10});
    default:  r = 0;
  endcase
  return r[31:0];
endfunction

`endif

// File: verification/tb_single_precision_unit.sv
// Testbench for the SIMD integer multiply path
// Directed edge cases, then LFSR-driven random instructions
// Every issued instruction is checked six edges later against the reference model
`timescale 1ns/1ps
`default_nettype none

module tb_single_precision_unit
  import spu_pkg::*;
();

  `include "spu_ref_model.svh"

  localparam int RESET_CYCLES   = 3;
  localparam int N_DIRECTED     = 15;
  localparam int N_RANDOM       = 2000;
  // Whole run plus pipe drain and margin
  localparam int TIMEOUT_CYCLES = RESET_CYCLES + N_DIRECTED + N_RANDOM + PIPE_STAGES + 20;

  logic                clock;
  logic                reset;
  instr_format_e       instr_format;
  logic [OPCODE_W-1:0] opcode;
  reg128_t             src_a;
  reg128_t             src_b;
  reg128_t             src_c;
  logic [IMM_W-1:0]    imm;
  addr_t               dest_addr;
  logic                reg_write;
  logic                branch_taken;
  reg128_t             result_data;
  addr_t               result_addr;
  logic                result_write;

  // Expected results, front entry is the next one due
  reg128_t exp_data[$];
  addr_t   exp_addr[$];
  logic    exp_write[$];
  int      exp_due[$];

  logic [15:0] lfsr;
  int          cycle;
  logic        checking;

  single_precision_unit single_precision_unit_i (
    .clock        (clock),
    .reset        (reset),
    .instr_format (instr_format),
    .opcode       (opcode),
    .src_a        (src_a),
    .src_b        (src_b),
    .src_c        (src_c),
    .imm          (imm),
    .dest_addr    (dest_addr),
    .reg_write    (reg_write),
    .branch_taken (branch_taken),
    .result_data  (result_data),
    .result_addr  (result_addr),
    .result_write (result_write)
  );

  always #4 clock = ~clock;

  // Cycle count and hang guard
  always @(posedge clock) begin
    cycle <= cycle + 1;
    if (cycle >= TIMEOUT_CYCLES) begin
      $display("Timeout, run still busy after %0d cycles", cycle);
      $display("Errors found");
      $fatal(1);
    end
  end

  // 16-bit Fibonacci LFSR, taps 16 14 13 11, one step per bit
  function automatic logic [127:0] rand_bits(int n);
    logic [127:0] v;
    logic         fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], fb};
      v    = {v[126:0], fb};
    end
    return v;
  endfunction

  task automatic check_data(input string name, input reg128_t got, input reg128_t exp);
    if (got !== exp) begin
      $display("ERR %s got %h expected %h", name, got, exp);
      $display("Errors found");
      $fatal(1);
    end
  endtask

  task automatic check_addr(input string name, input addr_t got, input addr_t exp);
    if (got !== exp) begin
      $display("ERR %s got %h expected %h", name, got, exp);
      $display("Errors found");
      $fatal(1);
    end
  endtask

  task automatic check_write(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("ERR %s got %h expected %h", name, got, exp);
      $display("Errors found");
      $fatal(1);
    end
  endtask

  // Drive one instruction after the next edge and queue its expected result
  task automatic issue(input logic [2:0] fmt, input logic [OPCODE_W-1:0] opc,
                       input reg128_t a, input reg128_t b, input reg128_t c,
                       input logic [IMM_W-1:0] im, input addr_t addr,
                       input logic wr, input logic br);
    mul_op_e op;
    logic    killed;
    reg128_t data;
    @(posedge clock);
    #1;
    instr_format = instr_format_e'(fmt);
    opcode       = opc;
    src_a        = a;
    src_b        = b;
    src_c        = c;
    imm          = im;
    dest_addr    = addr;
    reg_write    = wr;
    branch_taken = br;
    op     = model_op(fmt, opc);
    // Taken branch, nop or undecoded encoding all leave a bubble
    killed = br || (fmt == 3'd0 && opc[OPCODE_W-1:1] == '0) || (op == OP_NONE);
    data   = '0;
    for (int i = 0; i < LANES; i++) begin
      data[i*WORD_W +: WORD_W] = model_lane(op, a[i*WORD_W +: WORD_W],
        b[i*WORD_W +: WORD_W], c[i*WORD_W +: WORD_W], im[9:0]);
    end
    exp_data.push_back(killed ? '0 : data);
    exp_addr.push_back(killed ? '0 : addr);
    exp_write.push_back(killed ? 1'b0 : wr);
    // Sampled at the next edge, visible after five more
    exp_due.push_back(cycle + PIPE_STAGES);
  endtask

  // Outputs are compared mid-cycle, away from both edges
  always @(negedge clock) begin
    if (checking) begin
      if (exp_due.size() > 0 && exp_due[0] == cycle) begin
        check_data("result_data", result_data, exp_data.pop_front());
        check_addr("result_addr", result_addr, exp_addr.pop_front());
        check_write("result_write", result_write, exp_write.pop_front());
        void'(exp_due.pop_front());
      end else begin
        // Nothing due, so the write-back port must be idle
        check_data("result_data", result_data, '0);
        check_addr("result_addr", result_addr, '0);
        check_write("result_write", result_write, 1'b0);
      end
    end
  end

  initial begin
    logic [2:0]          sel;
    logic [1:0]          odd;
    logic [2:0]          fmt;
    logic [OPCODE_W-1:0] opc;
    logic                br;
    lfsr         = 16'd8548;
    cycle        = 0;
    checking     = 1'b0;
    clock        = 1'b0;
    reset        = 1'b1;
    instr_format = FMT_RR;
    opcode       = '0;
    src_a        = '0;
    src_b        = '0;
    src_c        = '0;
    imm          = '0;
    dest_addr    = '0;
    reg_write    = 1'b0;
    branch_taken = 1'b1;
    repeat (RESET_CYCLES) @(posedge clock);
    #1;
    reset    = 1'b0;
    checking = 1'b1;

    // All seven ops back to back, each with its own address
    issue(3'd0, OPC_MPY, {4{32'h0001_8000}}, {4{32'h0000_7fff}}, '0, '0, 7'd1, 1'b1, 1'b0);
    issue(3'd0, OPC_MPYU, {4{32'h1234_ffff}}, {4{32'hffff_ffff}}, '0, '0, 7'd2, 1'b1, 1'b0);
    issue(3'd0, OPC_MPYH, {4{32'hffff_0001}}, {4{32'h0000_ffff}}, '0, '0, 7'd3, 1'b1, 1'b0);
    issue(3'd0, OPC_MPYS, {4{32'h0000_8000}}, {4{32'h0000_7fff}}, '0, '0, 7'd4, 1'b1, 1'b0);
    issue(3'd1, {7'h55, OPC_MPYA}, {4{32'h0000_7fff}}, {4{32'h0000_7fff}},
          {4{32'hffff_ffff}}, '0, 7'd5, 1'b1, 1'b0);
    issue(3'd4, {3'd5, OPC_MPYI}, {4{32'h0000_8000}}, '0, '0, 18'h00200, 7'd6, 1'b1, 1'b0);
    issue(3'd4, {3'd2, OPC_MPYUI}, {4{32'h0000_ffff}}, '0, '0, 18'h003ff, 7'd7, 1'b1, 1'b0);
    // Sign and truncation corners across different lanes
    issue(3'd0, OPC_MPYS, 128'h0000_ffff_0000_8000_0000_7fff_0000_0001,
          128'h0000_ffff_0000_8000_0000_8000_0000_ffff, '0, '0, 7'd8, 1'b1, 1'b0);
    issue(3'd0, OPC_MPYH, 128'hffff_ffff_8000_0002_7fff_ffff_0001_0000,
          128'h0000_ffff_0000_8000_0000_0002_0000_ffff, '0, '0, 7'd9, 1'b1, 1'b0);
    issue(3'd1, {7'h00, OPC_MPYA}, {4{32'h0000_8000}}, {4{32'h0000_8000}},
          {4{32'hc000_0000}}, '0, 7'd10, 1'b1, 1'b0);
    issue(3'd4, {3'd0, OPC_MPYUI}, {4{32'h0000_8001}}, '0, '0, 18'h3fe00, 7'd11, 1'b1, 1'b0);
    // Bubbles from branch, nop and an unused format
    issue(3'd0, OPC_MPY, {4{32'h0000_1234}}, {4{32'h0000_0567}}, '0, '0, 7'd12, 1'b1, 1'b1);
    issue(3'd0, 11'h001, {4{32'h0000_1234}}, {4{32'h0000_0567}}, '0, '0, 7'd13, 1'b1, 1'b0);
    issue(3'd2, OPC_MPY, {4{32'h0000_1234}}, {4{32'h0000_0567}}, '0, '0, 7'd14, 1'b1, 1'b0);
    // Result computed but not written back
    issue(3'd0, OPC_MPY, {4{32'h0000_1234}}, {4{32'h0000_0567}}, '0, '0, 7'd15, 1'b0, 1'b0);

    for (int n = 0; n < N_RANDOM; n++) begin
      sel = 3'(rand_bits(3));
      br  = 1'b0;
      fmt = 3'd0;
      case (sel)
        3'd0: opc = OPC_MPY;
        3'd1: opc = OPC_MPYU;
        3'd2: opc = OPC_MPYH;
        3'd3: opc = OPC_MPYS;
        3'd4: begin
          fmt = 3'd1;
          opc = {7'(rand_bits(7)), OPC_MPYA};
        end
        3'd5: begin
          fmt = 3'd4;
          opc = {3'(rand_bits(3)), OPC_MPYI};
        end
        3'd6: begin
          fmt = 3'd4;
          opc = {3'(rand_bits(3)), OPC_MPYUI};
        end
        default: begin
          odd = 2'(rand_bits(2));
          opc = OPCODE_W'(rand_bits(OPCODE_W));
          fmt = 3'(rand_bits(3));
          // 0 nop, 1 unused format, 2 anything, 3 squashed mpy
          if (odd == 2'd0) begin
            fmt = 3'd0;
            opc = {10'd0, opc[0]};
          end else if (odd == 2'd1 && (fmt == 3'd0 || fmt == 3'd1 || fmt == 3'd4)) begin
            fmt = 3'd7;
          end else if (odd == 2'd3) begin
            fmt = 3'd0;
            opc = OPC_MPY;
            br  = 1'b1;
          end
        end
      endcase
      br = br || (4'(rand_bits(4)) == 4'd0);
      issue(fmt, opc, rand_bits(REG_W), rand_bits(REG_W), rand_bits(REG_W),
            IMM_W'(rand_bits(IMM_W)), ADDR_W'(rand_bits(ADDR_W)), 1'(rand_bits(1)), br);
    end

    // Park the inputs on a bubble and let the pipe drain
    @(posedge clock);
    #1;
    branch_taken = 1'b1;
    while (exp_due.size() != 0) @(negedge clock);
    @(negedge clock);

    $display("No errors");
    $finish;
  end

endmodule

`default_nettype wire

// File: hw/single_precision_unit.sv
// Top of the integer multiply path of the four-lane SIMD unit
// One instruction per cycle in, results out PIPE_STAGES edges later
// Decoder and lanes are combinational, the pipe holds all state
`timescale 1ns/1ps
`default_nettype none

module single_precision_unit
  import spu_pkg::*;
(
  input  logic                        clock,
  input  logic                        reset,
  input  instr_format_e               instr_format,
  input  logic          [OPCODE_W-1:0] opcode,
  input  reg128_t                     src_a,
  input  reg128_t                     src_b,
  input  reg128_t                     src_c,
  input  logic          [IMM_W-1:0]   imm,
  input  addr_t                       dest_addr,
  input  logic                        reg_write,
  input  logic                        branch_taken,
  output reg128_t                     result_data,
  output addr_t                       result_addr,
  output logic                        result_write
);

  // Decoded op shared by all lanes
  mul_op_e mul_op;
  logic    kill;
  // Concatenated lane outputs
  reg128_t lane_result;

  instr_decoder instr_decoder_i (
    .instr_format (instr_format),
    .opcode       (opcode),
    .branch_taken (branch_taken),
    .mul_op       (mul_op),
    .kill         (kill)
  );

  // Lane i works on bits 32i..32i+31 of every source
  for (genvar i = 0; i < LANES; i++) begin : gen_lane
    mul_lane mul_lane_i (
      .mul_op (mul_op),
      .a      (src_a[i*WORD_W +: WORD_W]),
      .b      (src_b[i*WORD_W +: WORD_W]),
      .c      (src_c[i*WORD_W +: WORD_W]),
      .imm10  (imm[9:0]),
      .result (lane_result[i*WORD_W +: WORD_W])
    );
  end

  // Address and write flag bypass the decoder, squash happens in the pipe
  result_pipe result_pipe_i (
    .clock     (clock),
    .reset     (reset),
    .kill      (kill),
    .data_in   (lane_result),
    .addr_in   (dest_addr),
    .write_in  (reg_write),
    .data_out  (result_data),
    .addr_out  (result_addr),
    .write_out (result_write)
  );

endmodule

`default_nettype wire

// File: hw/result_pipe.sv
// Fixed-latency result pipe feeding the write-back port
// Carries data, destination and write flag through PIPE_STAGES registers
// Killed instructions enter as all-zero bubbles
`timescale 1ns/1ps
`default_nettype none

module result_pipe
  import spu_pkg::*;
(
  input  logic    clock,
  input  logic    reset,
  input  logic    kill,
  input  reg128_t data_in,
  input  addr_t   addr_in,
  input  logic    write_in,
  output reg128_t data_out,
  output addr_t   addr_out,
  output logic    write_out
);

  // Stage 0 is the entry, the top stage drives the outputs
  reg128_t [PIPE_STAGES-1:0] data_q;
  addr_t   [PIPE_STAGES-1:0] addr_q;
  logic    [PIPE_STAGES-1:0] write_q;
  // Marks stages holding a squashed entry
  logic    [PIPE_STAGES-1:0] kill_q;

  // Entry values after squash
  reg128_t data_next;
  addr_t   addr_next;
  logic    write_next;

  assign data_next  = kill ? '0 : data_in;
  assign addr_next  = kill ? '0 : addr_in;
  assign write_next = kill ? 1'b0 : write_in;

  always_ff @(posedge clock) begin
    if (reset) begin
      data_q  <= '0;
      addr_q  <= '0;
      write_q <= '0;
      kill_q  <= '0;
    end else begin
      // Shift everything up one stage each cycle
      data_q  <= {data_q[PIPE_STAGES-2:0], data_next};
      addr_q  <= {addr_q[PIPE_STAGES-2:0], addr_next};
      write_q <= {write_q[PIPE_STAGES-2:0], write_next};
      kill_q  <= {kill_q[PIPE_STAGES-2:0], kill};
    end
  end

  assign data_out  = data_q[PIPE_STAGES-1];
  assign addr_out  = addr_q[PIPE_STAGES-1];
  assign write_out = write_q[PIPE_STAGES-1];

  // Whole chain is clean once reset has been seen
  assert property (@(posedge clock)
    reset |=> (data_q == '0) && (addr_q == '0) && (write_q == '0))
    else $error("result pipe not cleared by reset");

  // A bubble stays a bubble all the way up the chain
  for (genvar s = 0; s < PIPE_STAGES; s++) begin : gen_kill_chk
    assert property (@(posedge clock) disable iff (reset)
      kill_q[s] |-> (data_q[s] == '0) && (addr_q[s] == '0) && !write_q[s])
      else $error("killed entry carries payload in stage %0d", s);
  end

endmodule

`default_nettype wire

// File: hw/mul_lane.sv
// One 32-bit lane of the multiply path
// Halfword products with the per-op shift, add or immediate operand
// Combinational, instantiated once per lane by the top level
`timescale 1ns/1ps
`default_nettype none

module mul_lane
  import spu_pkg::*;
(
  input  mul_op_e      mul_op,
  input  word_t        a,
  input  word_t        b,
  input  word_t        c,
  input  logic   [9:0] imm10,
  output word_t        result
);

  // Operand halves
  logic [HALF_W-1:0] a_lo;
  logic [HALF_W-1:0] a_hi;
  logic [HALF_W-1:0] b_lo;
  // Immediate sign-extended to a halfword
  logic [HALF_W-1:0] imm16;

  // Candidate products, all kept to lane width
  logic signed [WORD_W-1:0] prod_ss;
  word_t                    prod_uu;
  word_t                    prod_hl;
  logic signed [WORD_W-1:0] prod_si;
  word_t                    prod_ui;

  assign a_lo  = a[HALF_W-1:0];
  assign a_hi  = a[WORD_W-1:HALF_W];
  assign b_lo  = b[HALF_W-1:0];
  assign imm16 = {{(HALF_W-10){imm10[9]}}, imm10};

  // Signed 16x16 fits in 32 bits exactly
  assign prod_ss = $signed(a_lo) * $signed(b_lo);
  assign prod_uu = a_lo * b_lo;
  // Only the low half survives the shift, so signedness does not matter
  assign prod_hl = a_hi * b_lo;
  assign prod_si = $signed(a_lo) * $signed(imm16);
  // mpyui reads the extended immediate as unsigned
  assign prod_ui = a_lo * imm16;

  always_comb begin
    case (mul_op)
      OP_MPY:   result = prod_ss;
      OP_MPYU:  result = prod_uu;
      OP_MPYH:  result = prod_hl << HALF_W;
      // Arithmetic shift keeps the product sign
      OP_MPYS:  result = prod_ss >>> HALF_W;
      // Wraps to 32 bits
      OP_MPYA:  result = prod_ss + c;
      OP_MPYI:  result = prod_si;
      OP_MPYUI: result = prod_ui;
      default:  result = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: hw/instr_decoder.sv
// Decodes format and opcode into a lane operation for the multiply path
// Also flags instructions that must enter the pipe as bubbles
// Purely combinational, sits in front of the lanes and the result pipe
`timescale 1ns/1ps
`default_nettype none

module instr_decoder
  import spu_pkg::*;
(
  input  instr_format_e              instr_format,
  input  logic          [OPCODE_W-1:0] opcode,
  input  logic                       branch_taken,
  output mul_op_e                    mul_op,
  output logic                       kill
);

  // Nop lives in the RR space with the top ten opcode bits clear
  logic is_nop;

  always_comb begin
    mul_op = OP_NONE;
    case (instr_format)
      // Full 11-bit opcode compare
      FMT_RR: begin
        case (opcode)
          OPC_MPY:  mul_op = OP_MPY;
          OPC_MPYU: mul_op = OP_MPYU;
          OPC_MPYH: mul_op = OP_MPYH;
          OPC_MPYS: mul_op = OP_MPYS;
          default:  mul_op = OP_NONE;
        endcase
      end
      // Three-source format, opcode in the low bits
      FMT_RRR: begin
        if (opcode[$bits(OPC_MPYA)-1:0] == OPC_MPYA) begin
          mul_op = OP_MPYA;
        end
      end
      // Immediate format, 8-bit opcode
      FMT_RI10: begin
        case (opcode[$bits(OPC_MPYI)-1:0])
          OPC_MPYI:  mul_op = OP_MPYI;
          OPC_MPYUI: mul_op = OP_MPYUI;
          default:   mul_op = OP_NONE;
        endcase
      end
      // Unused formats stay OP_NONE
      default: mul_op = OP_NONE;
    endcase
  end

  assign is_nop = (instr_format == FMT_RR) && (opcode[OPCODE_W-1:1] == '0);

  // Taken branch squashes whatever was issued this cycle
  // Unknown encodings are zeroed the same way
  assign kill = branch_taken || is_nop || (mul_op == OP_NONE);

endmodule

`default_nettype wire

// File: hw/spu_pkg.sv
// Shared widths, opcode values and enums for the SIMD multiply unit
// Imported by every RTL module and by the testbench
`default_nettype none

package spu_pkg;

  // Register geometry
  localparam int LANES  = 4;
  localparam int WORD_W = 32;
  localparam int HALF_W = 16;
  localparam int REG_W  = LANES * WORD_W;

  // Instruction fields
  localparam int ADDR_W   = 7;
  localparam int OPCODE_W = 11;
  // Only the low 10 bits carry the immediate for RI10
  localparam int IMM_W    = 18;

  // Result registers between issue and write-back
  localparam int PIPE_STAGES = 6;

  typedef logic [WORD_W-1:0] word_t;
  typedef logic [REG_W-1:0]  reg128_t;
  typedef logic [ADDR_W-1:0] addr_t;

  // Formats not listed here are killed by the decoder
  typedef enum logic [2:0] {
    FMT_RR   = 3'd0,
    FMT_RRR  = 3'd1,
    FMT_RI10 = 3'd4
  } instr_format_e;

  // Operation handed to each lane
  typedef enum logic [2:0] {
    OP_NONE,
    OP_MPY,
    OP_MPYU,
    OP_MPYH,
    OP_MPYS,
    OP_MPYA,
    OP_MPYI,
    OP_MPYUI
  } mul_op_e;

  // RR opcodes, full 11 bits
  localparam logic [OPCODE_W-1:0] OPC_MPY  = 11'b01111000100;
  localparam logic [OPCODE_W-1:0] OPC_MPYU = 11'b01111001100;
  localparam logic [OPCODE_W-1:0] OPC_MPYH = 11'b01111000101;
  localparam logic [OPCODE_W-1:0] OPC_MPYS = 11'b01111000111;
  // RRR opcode, low 4 bits
  localparam logic [3:0] OPC_MPYA = 4'b1100;
  // RI10 opcodes, low 8 bits
  localparam logic [7:0] OPC_MPYI  = 8'b01110100;
  localparam logic [7:0] OPC_MPYUI = 8'b01110101;

endpackage

`default_nettype wire
